// File: all.f
design/cmp_pkg.sv
design/credit_rx_fifo.sv
design/cmp_config_parser.sv
design/config_store.sv
design/hash_table.sv
design/cmp_subsystem_top.sv
verification/tb_cmp_subsystem.sv

// File: design/cmp_config_parser.sv
`timescale 1ns/100ps

module cmp_config_parser (
	input  logic                            CLK,
	input  logic                            arst_n,
	input  logic                            mode_cmp,
	input  logic                            fifo_valid,
	input  logic [7:0]                      fifo_data,
	output logic                            fifo_pop,
	input  logic                            cmp_config_applied,
	output logic                            new_cmp_config,
	output logic                            config_ready,
	output logic                            error,
	output logic                            store_wr_en,
	output logic [cmp_pkg::STORE_ADDR_W-1:0] store_wr_addr,
	output logic [7:0]                      store_wr_data,
	output logic                            tbl_clear,
	output logic                            tbl_wr_en,
	output logic [7:0]                      tbl_wr_byte,
	output logic [cmp_pkg::HASH_COUNT_W-1:0] hash_count
);
	import cmp_pkg::*;

	parser_state_t           state;
	// next salt byte address within SALT_BASE..SALT_BASE+15
	logic [STORE_ADDR_W-1:0] salt_addr;
	// byte index inside the 4-byte iteration count
	logic [1:0]              iter_cnt;
	// byte index inside the comparator data at 4 bytes per hash
	logic [HASH_COUNT_W+1:0] cmp_cnt;
	// low byte of the hash count held until the high byte arrives
	logic [7:0]              count_lo;
	logic [15:0]             count_full;
	logic                    take;

	// consume a byte whenever one is present except while waiting on the engine
	// a sticky error freezes the parser and lets the FIFO fill up
	assign take = fifo_valid && !error && (state != ST_WAIT_APPLIED);
	assign fifo_pop = take;

	assign count_full = {fifo_data, count_lo};

	// salt length, salt and iteration bytes land in the config store
	assign store_wr_en = take &&
		(state == ST_SALT_LEN || state == ST_SALT || state == ST_ITER);
	assign store_wr_data = fifo_data;

	always_comb begin
		case (state)
			ST_SALT_LEN: store_wr_addr = STORE_ADDR_W'(SALT_LEN_ADDR);
			ST_SALT:     store_wr_addr = salt_addr;
			default:     store_wr_addr = STORE_ADDR_W'(ITER_BASE) + STORE_ADDR_W'(iter_cnt);
		endcase
	end

	// any start byte empties the table including a bad one
	assign tbl_clear = take && (state == ST_START);

	// hash bytes stream straight to the table assembler
	assign tbl_wr_en = take && (state == ST_CMP_DATA);
	assign tbl_wr_byte = fifo_data;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_START;
			salt_addr <= STORE_ADDR_W'(SALT_BASE);
			iter_cnt <= '0;
			cmp_cnt <= '0;
			count_lo <= '0;
			hash_count <= '0;
			new_cmp_config <= 1'b0;
			config_ready <= 1'b0;
			error <= 1'b0;
		end else if (state == ST_WAIT_APPLIED) begin
			// stalled here until the engine acknowledges
			if (cmp_config_applied && !error) begin
				new_cmp_config <= 1'b0;
				state <= ST_SALT_LEN;
			end
		end else if (take) begin
			case (state)
				ST_START: begin
					// previous configuration no longer valid
					config_ready <= 1'b0;
					hash_count <= '0;
					if (fifo_data != 8'd0) begin
						error <= 1'b1;
					end else begin
						new_cmp_config <= 1'b1;
						state <= ST_WAIT_APPLIED;
					end
				end

				ST_SALT_LEN: begin
					salt_addr <= STORE_ADDR_W'(SALT_BASE);
					iter_cnt <= '0;
					if (fifo_data == 8'd0 || fifo_data > 8'(MAX_SALT_LEN))
						error <= 1'b1;
					else
						state <= ST_SALT;
				end

				// always 16 salt bytes on the wire as short salts are padded
				ST_SALT: begin
					salt_addr <= salt_addr + 1'b1;
					if (salt_addr == STORE_ADDR_W'(SALT_BASE + MAX_SALT_LEN - 1))
						state <= ST_ITER;
				end

				ST_ITER: begin
					iter_cnt <= iter_cnt + 1'b1;
					if (iter_cnt == 2'd3)
						state <= ST_COUNT_LO;
				end

				ST_COUNT_LO: begin
					count_lo <= fifo_data;
					state <= ST_COUNT_HI;
				end

				// full 16-bit count is checked once both bytes are known
				ST_COUNT_HI: begin
					cmp_cnt <= '0;
					if (count_full > 16'(NUM_HASHES)) begin
						error <= 1'b1;
					end else if (!mode_cmp && count_full != 16'd0) begin
						// hash data is not accepted with the comparator disabled
						error <= 1'b1;
					end else begin
						hash_count <= HASH_COUNT_W'(count_full);
						if (mode_cmp && count_full != 16'd0)
							state <= ST_CMP_DATA;
						else
							state <= ST_MAGIC;
					end
				end

				ST_CMP_DATA: begin
					cmp_cnt <= cmp_cnt + 1'b1;
					// last byte of the last hash
					if (cmp_cnt == {hash_count - 1'b1, 2'b11})
						state <= ST_MAGIC;
				end

				ST_MAGIC: begin
					if (fifo_data == CMP_MAGIC) begin
						config_ready <= 1'b1;
						state <= ST_START;
					end else begin
						error <= 1'b1;
					end
				end

				default: state <= ST_START;
			endcase
		end
	end

endmodule

// File: design/cmp_pkg.sv
package cmp_pkg;

	// input FIFO entries, also the credits a sender starts with
	localparam int FIFO_DEPTH = 16;

	// comparator table size and its index / count widths
	localparam int NUM_HASHES = 32;
	localparam int HASH_IDX_W = 5;
	// count covers 0 to NUM_HASHES inclusive, so one bit wider than the index
	localparam int HASH_COUNT_W = 6;

	localparam int MAX_SALT_LEN = 16;

	// closing byte of every config packet
	localparam logic [7:0] CMP_MAGIC = 8'hCC;

	// config store addressing
	localparam int STORE_ADDR_W = 5;
	// iteration count at 0..3, least significant byte first
	localparam int ITER_BASE = 0;
	localparam int SALT_LEN_ADDR = 4;
	// salt bytes at 8..23
	localparam int SALT_BASE = 8;

	typedef enum logic [3:0] {
		ST_START,
		ST_WAIT_APPLIED,
		ST_SALT_LEN,
		ST_SALT,
		ST_ITER,
		ST_COUNT_LO,
		ST_COUNT_HI,
		ST_CMP_DATA,
		ST_MAGIC
	} parser_state_t;

	typedef enum logic [1:0] {
		SR_IDLE,
		SR_SCAN,
		SR_DONE
	} search_state_t;

endpackage

// File: design/cmp_subsystem_top.sv
`timescale 1ns/100ps

module cmp_subsystem_top (
	input  logic                            CLK,
	input  logic                            arst_n,
	input  logic                            mode_cmp,
	input  logic                            in_valid,
	input  logic [7:0]                      in_data,
	output logic                            credit_return,
	input  logic                            cmp_config_applied,
	output logic                            new_cmp_config,
	output logic                            config_ready,
	output logic                            error,
	input  logic [cmp_pkg::STORE_ADDR_W-1:0] rd_addr,
	output logic [7:0]                      rd_data,
	input  logic                            cmp_req,
	input  logic [31:0]                     cmp_word,
	output logic                            cmp_done,
	output logic                            cmp_hit,
	output logic [cmp_pkg::HASH_IDX_W-1:0]   cmp_idx
);
	import cmp_pkg::*;

	// FIFO to parser
	logic                    fifo_valid;
	logic [7:0]              fifo_data;
	logic                    fifo_pop;

	// parser to config store
	logic                    store_wr_en;
	logic [STORE_ADDR_W-1:0] store_wr_addr;
	logic [7:0]              store_wr_data;

	// parser to hash table
	logic                    tbl_clear;
	logic                    tbl_wr_en;
	logic [7:0]              tbl_wr_byte;
	logic [HASH_COUNT_W-1:0] hash_count;

	credit_rx_fifo u_fifo (
		.CLK           (CLK),
		.arst_n        (arst_n),
		.in_valid      (in_valid),
		.in_data       (in_data),
		.fifo_pop      (fifo_pop),
		.fifo_valid    (fifo_valid),
		.fifo_data     (fifo_data),
		.credit_return (credit_return)
	);

	cmp_config_parser u_parser (
		.CLK                (CLK),
		.arst_n             (arst_n),
		.mode_cmp           (mode_cmp),
		.fifo_valid         (fifo_valid),
		.fifo_data          (fifo_data),
		.fifo_pop           (fifo_pop),
		.cmp_config_applied (cmp_config_applied),
		.new_cmp_config     (new_cmp_config),
		.config_ready       (config_ready),
		.error              (error),
		.store_wr_en        (store_wr_en),
		.store_wr_addr      (store_wr_addr),
		.store_wr_data      (store_wr_data),
		.tbl_clear          (tbl_clear),
		.tbl_wr_en          (tbl_wr_en),
		.tbl_wr_byte        (tbl_wr_byte),
		.hash_count         (hash_count)
	);

	config_store u_store (
		.CLK           (CLK),
		.arst_n        (arst_n),
		.store_wr_en   (store_wr_en),
		.store_wr_addr (store_wr_addr),
		.store_wr_data (store_wr_data),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data)
	);

	// searches are gated by config_ready so the table is never read mid-load
	hash_table u_table (
		.CLK          (CLK),
		.arst_n       (arst_n),
		.tbl_clear    (tbl_clear),
		.tbl_wr_en    (tbl_wr_en),
		.tbl_wr_byte  (tbl_wr_byte),
		.hash_count   (hash_count),
		.config_ready (config_ready),
		.cmp_req      (cmp_req),
		.cmp_word     (cmp_word),
		.cmp_done     (cmp_done),
		.cmp_hit      (cmp_hit),
		.cmp_idx      (cmp_idx)
	);

endmodule

// File: design/config_store.sv
`timescale 1ns/100ps

module config_store (
	input  logic                            CLK,
	input  logic                            arst_n,
	input  logic                            store_wr_en,
	input  logic [cmp_pkg::STORE_ADDR_W-1:0] store_wr_addr,
	input  logic [7:0]                      store_wr_data,
	input  logic [cmp_pkg::STORE_ADDR_W-1:0] rd_addr,
	output logic [7:0]                      rd_data
);
	import cmp_pkg::*;

	localparam int NUM_BYTES = 2 ** STORE_ADDR_W;

	// 0..3 iteration count, 4 salt length, 8..23 salt, rest unused
	logic [7:0] mem [NUM_BYTES];

	// unwritten locations read back as zero
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_BYTES; i++)
				mem[i] <= 8'd0;
		end else if (store_wr_en) begin
			mem[store_wr_addr] <= store_wr_data;
		end
	end

	// asynchronous read port for the engine
	assign rd_data = mem[rd_addr];

endmodule

// File: design/credit_rx_fifo.sv
`timescale 1ns/100ps

module credit_rx_fifo (
	input  logic       CLK,
	input  logic       arst_n,
	input  logic       in_valid,
	input  logic [7:0] in_data,
	input  logic       fifo_pop,
	output logic       fifo_valid,
	output logic [7:0] fifo_data,
	output logic       credit_return
);
	import cmp_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	logic [7:0]     mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// one extra bit so a completely full buffer is representable
	logic [PTR_W:0]   count;
	logic             push;
	logic             pop;

	// sender only writes while holding a credit so the buffer never overflows
	assign push = in_valid;
	// ignore a pop request against an empty buffer
	assign pop = fifo_pop && fifo_valid;

	assign fifo_valid = (count != '0);
	// head of queue shown combinationally
	assign fifo_data = mem[rd_ptr];

	// byte storage
	always_ff @(posedge CLK) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			// pointers wrap at the end of the buffer
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// every consumed byte hands one credit back one cycle later
			credit_return <= pop;
		end
	end

endmodule

// File: design/hash_table.sv
`timescale 1ns/100ps

module hash_table (
	input  logic                            CLK,
	input  logic                            arst_n,
	input  logic                            tbl_clear,
	input  logic                            tbl_wr_en,
	input  logic [7:0]                      tbl_wr_byte,
	input  logic [cmp_pkg::HASH_COUNT_W-1:0] hash_count,
	input  logic                            config_ready,
	input  logic                            cmp_req,
	input  logic [31:0]                     cmp_word,
	output logic                            cmp_done,
	output logic                            cmp_hit,
	output logic [cmp_pkg::HASH_IDX_W-1:0]   cmp_idx
);
	import cmp_pkg::*;

	logic [31:0]             mem [NUM_HASHES];

	// word assembler with the least significant byte first
	logic [1:0]              byte_cnt;
	logic [23:0]             word_buf;
	// index the next complete word goes to
	logic [HASH_IDX_W-1:0]   wr_idx;
	logic                    word_done;

	search_state_t           sr_state;
	logic [HASH_IDX_W-1:0]   scan_idx;
	logic [31:0]             key;
	logic                    last_entry;
	logic                    entry_match;

	assign word_done = tbl_wr_en && (byte_cnt == 2'd3);

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			byte_cnt <= '0;
			wr_idx <= '0;
		end else if (tbl_clear) begin
			byte_cnt <= '0;
			wr_idx <= '0;
		end else if (tbl_wr_en) begin
			byte_cnt <= byte_cnt + 1'b1;
			if (word_done)
				wr_idx <= wr_idx + 1'b1;
		end
	end

	// partial word bytes and completed table entries
	always_ff @(posedge CLK) begin
		if (tbl_wr_en && !word_done)
			word_buf[8*byte_cnt +: 8] <= tbl_wr_byte;
		if (word_done)
			mem[wr_idx] <= {tbl_wr_byte, word_buf};
	end

	// only entries below hash_count take part in the search
	assign entry_match = (hash_count != '0) && (mem[scan_idx] == key);
	assign last_entry = (HASH_COUNT_W'(scan_idx) + 1'b1 >= hash_count);

	// search key held for the whole scan
	always_ff @(posedge CLK) begin
		if (sr_state == SR_IDLE && cmp_req && config_ready)
			key <= cmp_word;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			sr_state <= SR_IDLE;
			scan_idx <= '0;
			cmp_hit <= 1'b0;
			cmp_idx <= '0;
		end else begin
			case (sr_state)
				// requests while not ready are dropped
				SR_IDLE: begin
					if (cmp_req && config_ready) begin
						scan_idx <= '0;
						sr_state <= SR_SCAN;
					end
				end

				// one entry per cycle where the first match wins
				SR_SCAN: begin
					if (entry_match) begin
						cmp_hit <= 1'b1;
						cmp_idx <= scan_idx;
						sr_state <= SR_DONE;
					end else if (last_entry) begin
						// miss reports index 0
						cmp_hit <= 1'b0;
						cmp_idx <= '0;
						sr_state <= SR_DONE;
					end else begin
						scan_idx <= scan_idx + 1'b1;
					end
				end

				SR_DONE: sr_state <= SR_IDLE;

				default: sr_state <= SR_IDLE;
			endcase
		end
	end

	// result registers are valid exactly while in SR_DONE
	assign cmp_done = (sr_state == SR_DONE);

endmodule

// File: verification/tb_cmp_subsystem.sv
`timescale 1ns/100ps

module tb_cmp_subsystem;
	import cmp_pkg::*;

	typedef logic [31:0] word_q_t[$];

	// longest packet is start, length, 16 salt, 4 iteration, 2 count, hashes and magic
	localparam int PKT_MAX = 25 + 4 * NUM_HASHES;
	// two full loads plus the short packets of the later tests
	localparam int TOTAL_BYTES = 2 * PKT_MAX + 8 * 26;
	localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 40 + 2000;

	logic                    CLK;
	logic                    arst_n;
	logic                    mode_cmp;
	logic                    in_valid;
	logic [7:0]              in_data;
	logic                    credit_return;
	logic                    cmp_config_applied;
	logic                    new_cmp_config;
	logic                    config_ready;
	logic                    error;
	logic [STORE_ADDR_W-1:0] rd_addr;
	logic [7:0]              rd_data;
	logic                    cmp_req;
	logic [31:0]             cmp_word;
	logic                    cmp_done;
	logic                    cmp_hit;
	logic [HASH_IDX_W-1:0]   cmp_idx;

	int seed = 86931;
	int err_cnt;
	int test_err0;
	int tests_run;
	int tests_failed;
	// sender side credit bookkeeping
	int sent_cnt;
	int returned_cnt;
	int done_cnt;
	logic ready_prev;

	logic [7:0]          pkt[$];
	logic [7:0]          salt_bytes[16];
	word_q_t             hashes;
	// expected {hit, idx} and the word of each query still in flight
	logic [HASH_IDX_W:0] exp_q[$];
	logic [31:0]         query_q[$];

	cmp_subsystem_top uut (
		.CLK                (CLK),
		.arst_n             (arst_n),
		.mode_cmp           (mode_cmp),
		.in_valid           (in_valid),
		.in_data            (in_data),
		.credit_return      (credit_return),
		.cmp_config_applied (cmp_config_applied),
		.new_cmp_config     (new_cmp_config),
		.config_ready       (config_ready),
		.error              (error),
		.rd_addr            (rd_addr),
		.rd_data            (rd_data),
		.cmp_req            (cmp_req),
		.cmp_word           (cmp_word),
		.cmp_done           (cmp_done),
		.cmp_hit            (cmp_hit),
		.cmp_idx            (cmp_idx)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// first equal entry of the list wins and a miss reports index 0
	function automatic logic [HASH_IDX_W:0] ref_lookup(input word_q_t list,
		input logic [31:0] key);
		logic [HASH_IDX_W:0] res;
		res = '0;
		for (int i = list.size() - 1; i >= 0; i--) begin
			if (list[i] == key)
				res = {1'b1, HASH_IDX_W'(i)};
		end
		return res;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return lo + (r % (hi - lo + 1));
	endfunction

	task automatic apply_reset();
		@(posedge CLK);
		arst_n <= 1'b0;
		in_valid <= 1'b0;
		cmp_req <= 1'b0;
		sent_cnt = 0;
		returned_cnt = 0;
		exp_q.delete();
		query_q.delete();
		repeat (16) @(posedge CLK);
		arst_n <= 1'b1;
		@(negedge CLK);
		if (error !== 1'b0 || config_ready !== 1'b0 || new_cmp_config !== 1'b0 ||
			credit_return !== 1'b0 || cmp_done !== 1'b0) begin
			$display("outputs not all low after reset");
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (err_cnt == test_err0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", tests_run, name, err_cnt - test_err0);
		end
		test_err0 = err_cnt;
	endtask

	task automatic fill_salt();
		for (int i = 0; i < 16; i++)
			salt_bytes[i] = $random(seed);
	endtask

	task automatic make_hashes(input int n);
		hashes.delete();
		for (int i = 0; i < n; i++) begin
			// about one entry in four repeats an earlier one
			if (i > 0 && rand_range(0, 3) == 0)
				hashes.push_back(hashes[rand_range(0, i - 1)]);
			else
				hashes.push_back($random(seed));
		end
	endtask

	task automatic make_packet(input logic [7:0] start_b, input logic [7:0] slen,
		input logic [31:0] iter, input logic [15:0] count, input logic [7:0] magic);
		pkt.delete();
		pkt.push_back(start_b);
		pkt.push_back(slen);
		for (int i = 0; i < 16; i++)
			pkt.push_back(salt_bytes[i]);
		for (int b = 0; b < 4; b++)
			pkt.push_back(iter[8*b +: 8]);
		pkt.push_back(count[7:0]);
		pkt.push_back(count[15:8]);
		// hash words go out least significant byte first
		foreach (hashes[i])
			for (int b = 0; b < 4; b++)
				pkt.push_back(hashes[i][8*b +: 8]);
		pkt.push_back(magic);
	endtask

	// sends the first n bytes of pkt only while a credit is held with random idle cycles
	task automatic send_bytes(input int n);
		int i;
		i = 0;
		while (i < n) begin
			@(posedge CLK);
			if (FIFO_DEPTH - sent_cnt + returned_cnt > 0 && rand_range(0, 3) != 0) begin
				in_valid <= 1'b1;
				in_data <= pkt[i];
				sent_cnt++;
				i++;
			end else begin
				in_valid <= 1'b0;
			end
		end
		@(posedge CLK);
		in_valid <= 1'b0;
	endtask

	task automatic wait_ready();
		int guard;
		guard = 0;
		do begin
			@(negedge CLK);
			guard++;
		end while (config_ready !== 1'b1 && guard < 200);
		if (config_ready !== 1'b1) begin
			$display("config_ready did not rise after the packet");
			err_cnt++;
		end
		if (error !== 1'b0) begin
			$display("MISMATCH error exp 0 got %h", error);
			err_cnt++;
		end
	endtask

	task automatic check_credits();
		// let the credit of the magic byte come back
		repeat (2) @(negedge CLK);
		if (returned_cnt !== sent_cnt) begin
			$display("MISMATCH credit_return count exp %h got %h", sent_cnt, returned_cnt);
			err_cnt++;
		end
	endtask

	task automatic check_store(input logic [7:0] slen, input logic [31:0] iter);
		logic [7:0] expv;
		for (int a = 0; a < SALT_BASE + MAX_SALT_LEN; a++) begin
			if (a <= SALT_LEN_ADDR || a >= SALT_BASE) begin
				if (a == SALT_LEN_ADDR)
					expv = slen;
				else if (a >= SALT_BASE)
					expv = salt_bytes[a - SALT_BASE];
				else
					expv = iter[8*(a - ITER_BASE) +: 8];
				@(posedge CLK);
				rd_addr <= STORE_ADDR_W'(a);
				@(negedge CLK);
				if (rd_data !== expv) begin
					$display("MISMATCH rd_data at %h exp %h got %h", a, expv, rd_data);
					err_cnt++;
				end
			end
		end
	endtask

	// one request and then a wait for its cmp_done
	task automatic query(input logic [31:0] w);
		int start_done;
		int guard;
		start_done = done_cnt;
		exp_q.push_back(ref_lookup(hashes, w));
		query_q.push_back(w);
		@(posedge CLK);
		cmp_req <= 1'b1;
		cmp_word <= w;
		@(posedge CLK);
		cmp_req <= 1'b0;
		guard = 0;
		while (done_cnt == start_done && guard < NUM_HASHES + 8) begin
			@(negedge CLK);
			guard++;
		end
		if (done_cnt == start_done) begin
			$display("no cmp_done for query word %h", w);
			err_cnt++;
			exp_q.delete(exp_q.size() - 1);
			query_q.delete(query_q.size() - 1);
		end
	endtask

	task automatic run_queries(input int n_stored, input int n_rand);
		for (int i = 0; i < n_stored; i++)
			query(hashes[rand_range(0, hashes.size() - 1)]);
		for (int i = 0; i < n_rand; i++)
			query($random(seed));
	endtask

	// fresh reset and a short or bad packet after which error must hold and ready stay low
	task automatic reject_case(input string name, input logic [7:0] start_b,
		input logic [7:0] slen, input logic [15:0] count, input logic [7:0] magic,
		input int nbytes);
		int guard;
		apply_reset();
		fill_salt();
		make_hashes(count > NUM_HASHES ? 0 : int'(count));
		make_packet(start_b, slen, $random(seed), count, magic);
		send_bytes(nbytes == 0 ? pkt.size() : nbytes);
		guard = 0;
		while (error !== 1'b1 && guard < 40) begin
			@(negedge CLK);
			guard++;
		end
		if (error !== 1'b1) begin
			$display("MISMATCH error exp 1 got %h", error);
			err_cnt++;
		end
		if (config_ready !== 1'b0) begin
			$display("MISMATCH config_ready exp 0 got %h", config_ready);
			err_cnt++;
		end
		finish_test(name);
	endtask

	// engine side acknowledging 1 to 8 cycles after new_cmp_config
	initial begin : engine_model
		int delay;
		forever begin
			@(negedge CLK);
			if (new_cmp_config === 1'b1 && cmp_config_applied === 1'b0) begin
				// a new packet withdraws the old configuration
				if (config_ready !== 1'b0) begin
					$display("MISMATCH config_ready exp 0 got %h", config_ready);
					err_cnt++;
				end
				delay = rand_range(1, 8);
				repeat (delay - 1) begin
					@(negedge CLK);
					if (new_cmp_config !== 1'b1) begin
						$display("new_cmp_config fell before cmp_config_applied");
						err_cnt++;
					end
				end
				@(posedge CLK);
				cmp_config_applied <= 1'b1;
				@(negedge CLK);
				while (new_cmp_config === 1'b1)
					@(negedge CLK);
				@(posedge CLK);
				cmp_config_applied <= 1'b0;
			end
		end
	end

	always @(negedge CLK) begin : link_monitor
		if (credit_return === 1'b1)
			returned_cnt++;
		if (FIFO_DEPTH - sent_cnt + returned_cnt < 0 ||
			FIFO_DEPTH - sent_cnt + returned_cnt > FIFO_DEPTH) begin
			$display("sender credit count out of range");
			err_cnt++;
		end
		// the magic byte is the last one sent, so its pop leaves no credit outstanding
		if (config_ready === 1'b1 && ready_prev !== 1'b1 && returned_cnt != sent_cnt) begin
			$display("config_ready rose before every packet byte was consumed");
			err_cnt++;
		end
		ready_prev = config_ready;
	end

	always @(negedge CLK) begin : compare_proc
		logic [HASH_IDX_W:0] expv;
		logic [31:0] key;
		if (cmp_done === 1'b1) begin
			done_cnt++;
			if (exp_q.size() == 0) begin
				$display("cmp_done without a pending query");
				err_cnt++;
			end else begin
				expv = exp_q.pop_front();
				key = query_q.pop_front();
				if (cmp_hit !== expv[HASH_IDX_W]) begin
					$display("MISMATCH cmp_hit for %h exp %h got %h", key,
						expv[HASH_IDX_W], cmp_hit);
					err_cnt++;
				end
				if (cmp_idx !== expv[HASH_IDX_W-1:0]) begin
					$display("MISMATCH cmp_idx for %h exp %h got %h", key,
						expv[HASH_IDX_W-1:0], cmp_idx);
					err_cnt++;
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	initial begin : main_seq
		logic [7:0] slen;
		logic [31:0] iter;
		word_q_t old_hashes;
		arst_n = 1'b0;
		mode_cmp = 1'b0;
		in_valid = 1'b0;
		in_data = 8'd0;
		cmp_config_applied = 1'b0;
		rd_addr = '0;
		cmp_req = 1'b0;
		cmp_word = 32'd0;
		apply_reset();

		// full table where credits run dry while the engine acknowledges
		@(posedge CLK);
		mode_cmp <= 1'b1;
		slen = 8'(rand_range(1, MAX_SALT_LEN));
		iter = $random(seed);
		fill_salt();
		make_hashes(NUM_HASHES);
		make_packet(8'h00, slen, iter, 16'(NUM_HASHES), CMP_MAGIC);
		send_bytes(pkt.size());
		wait_ready();
		check_credits();
		finish_test("credit flow");

		check_store(slen, iter);
		finish_test("config store");

		// last entry forces a full scan
		query(hashes[NUM_HASHES - 1]);
		run_queries(24, 12);
		finish_test("compare full table");

		// second packet replaces table and store
		old_hashes = hashes;
		slen = 8'(rand_range(1, MAX_SALT_LEN));
		iter = $random(seed);
		fill_salt();
		make_hashes(rand_range(1, NUM_HASHES));
		make_packet(8'h00, slen, iter, 16'(hashes.size()), CMP_MAGIC);
		send_bytes(pkt.size());
		wait_ready();
		check_credits();
		check_store(slen, iter);
		run_queries(16, 8);
		// words of the first load still sit in the table past the new count
		for (int i = 3; i < NUM_HASHES; i += 4)
			query(old_hashes[i]);
		finish_test("reload and handshake");

		// comparator disabled with an empty hash list
		old_hashes = hashes;
		@(posedge CLK);
		mode_cmp <= 1'b0;
		apply_reset();
		fill_salt();
		make_hashes(0);
		make_packet(8'h00, 8'd16, $random(seed), 16'd0, CMP_MAGIC);
		send_bytes(pkt.size());
		wait_ready();
		// entry 0 still holds a word of the previous load
		query(old_hashes[0]);
		run_queries(0, 8);
		finish_test("compare disabled");
		reject_case("compare disabled with hashes", 8'h00, 8'd8, 16'd3, CMP_MAGIC, 24);

		@(posedge CLK);
		mode_cmp <= 1'b1;
		reject_case("salt length 0", 8'h00, 8'd0, 16'd1, CMP_MAGIC, 2);
		reject_case("salt length 17", 8'h00, 8'd17, 16'd1, CMP_MAGIC, 2);
		reject_case("hash count over table", 8'h00, 8'd8, 16'(NUM_HASHES + 1), CMP_MAGIC, 24);
		reject_case("wrong magic", 8'h00, 8'd8, 16'd1, 8'h5A, 0);
		reject_case("nonzero start byte", 8'h01, 8'd8, 16'd1, CMP_MAGIC, 1);

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
